/* trace_pkg.sv */
// Retirement tracer shared types
package trace_pkg;

  localparam int TRACE_DEPTH = 4;
  localparam int TAG_W       = $clog2(TRACE_DEPTH);
  localparam int CNT_W       = TAG_W + 1;
  localparam int XLEN        = 32;

  // Encodings of the instructions that retire one cycle after WB
  localparam logic [31:0] INSN_MRET     = 32'h3020_0073;
  localparam logic [31:0] INSN_URET     = 32'h0020_0073;
  localparam logic [31:0] INSN_EBREAK   = 32'h0010_0073;
  localparam logic [15:0] INSN_C_EBREAK = 16'h9002;

  typedef enum logic [1:0] {
    RK_NORMAL,
    RK_DELAYED,
    RK_DEBUG_EBREAK
  } retire_kind_e;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
    logic            compressed;
    logic            id_valid;
    logic            is_decoding;
    logic            is_illegal;
    logic            trigger_match;
    logic            ebrk_insn;
  } dec_info_t;

  typedef struct packed {
    logic ex_valid;
    logic data_misaligned;
    logic wb_bypass;
    logic wb_valid;
    logic debug_mode;
    logic ebrk_force_debug_mode;
  } pipe_ctrl_t;

  typedef struct packed {
    logic            we;
    logic [5:0]      addr;
    logic [XLEN-1:0] wdata;
  } reg_wr_t;

  typedef struct packed {
    logic            req;
    logic            gnt;
    logic            we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } mem_acc_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
    logic            compressed;
    logic            ebreak;
    logic            wb_bypass;
    logic            misaligned;
    logic            rd_written;
    logic [5:0]      rd_addr;
    logic [XLEN-1:0] rd_wdata;
    logic            mem_valid;
    logic            mem_we;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic [31:0]     cycle;
  } trace_rec_t;

  // Tagged command from a pipeline stage to the record store
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic             set_wb_bypass;
    logic             set_misaligned;
    reg_wr_t          rd;
    logic             mem_set;
    logic             mem_we;
    logic [XLEN-1:0]  mem_addr;
    logic [XLEN-1:0]  mem_wdata;
    logic             retire;
    // WB-delay occupant retires alongside the WB stage
    logic             retire_wbd;
    logic [TAG_W-1:0] wbd_tag;
  } trace_upd_t;

endpackage

/* trace_stage_tracker.sv */
// Pipeline stage tracker
`timescale 1ns/1ns

module trace_stage_tracker (
  input  logic                          clk_i,
  input  logic                          rst_n,
  input  trace_pkg::dec_info_t          dec,
  input  trace_pkg::pipe_ctrl_t         pipe,
  input  trace_pkg::reg_wr_t            ex_wr,
  input  trace_pkg::reg_wr_t            wb_wr,
  input  trace_pkg::mem_acc_t           mem,
  input  logic [trace_pkg::TAG_W-1:0]   alloc_tag,
  input  logic                          full,
  output logic                          alloc,
  output trace_pkg::trace_rec_t         alloc_rec,
  output logic                          alloc_retired,
  output trace_pkg::trace_upd_t         upd_ex,
  output trace_pkg::trace_upd_t         upd_wb,
  output logic                          protocol_error,
  output logic                          overflow
);

  logic                        ex_vld_q, wb_vld_q, wbd_vld_q;
  logic                        ex_mis_q;
  logic [trace_pkg::TAG_W-1:0] ex_tag_q, wb_tag_q, wbd_tag_q;
  trace_pkg::retire_kind_e     ex_kind_q, wb_kind_q, dec_kind;
  logic [31:0]                 cycle_q;

  logic new_insn, new_ebrk;
  logic ex_hold, ex_leave, ex_bypass, ex_to_wb;
  logic wb_done, wb_to_wbd, wb_retire, wb_to_ex;
  logic mem_fire, err_ex, err_wb, err_mem;

  // mret, uret and ebreak need one extra cycle after WB
  function automatic trace_pkg::retire_kind_e classify(input logic [31:0] instr,
                                                       input logic        compressed);
    trace_pkg::retire_kind_e kind;
    kind = trace_pkg::RK_NORMAL;
    if (compressed) begin
      if (instr[15:0] == trace_pkg::INSN_C_EBREAK)
        kind = trace_pkg::RK_DELAYED;
    end else if (instr == trace_pkg::INSN_MRET || instr == trace_pkg::INSN_URET ||
                 instr == trace_pkg::INSN_EBREAK) begin
      kind = trace_pkg::RK_DELAYED;
    end
    return kind;
  endfunction

  // --------------------------------------------------
  // Decode side
  // --------------------------------------------------
  assign new_insn = dec.id_valid && dec.is_decoding && !dec.is_illegal;
  // Ebreak into debug skips the pipeline
  assign new_ebrk = !new_insn && dec.is_decoding && dec.ebrk_insn && !dec.trigger_match &&
                    (pipe.debug_mode || pipe.ebrk_force_debug_mode);
  assign dec_kind = new_ebrk ? trace_pkg::RK_DEBUG_EBREAK : classify(dec.instr, dec.compressed);

  assign alloc         = (new_insn || new_ebrk) && !full;
  assign alloc_retired = (dec_kind == trace_pkg::RK_DEBUG_EBREAK);

  always_comb begin
    alloc_rec            = '0;
    alloc_rec.pc         = dec.pc;
    alloc_rec.instr      = dec.instr;
    alloc_rec.compressed = dec.compressed;
    alloc_rec.ebreak     = new_ebrk;
    alloc_rec.cycle      = cycle_q;
  end

  // --------------------------------------------------
  // Stage movement
  // --------------------------------------------------
  assign ex_hold   = ex_vld_q && pipe.ex_valid && pipe.data_misaligned;
  assign ex_leave  = ex_vld_q && pipe.ex_valid && !pipe.data_misaligned;
  assign ex_bypass = ex_leave && pipe.wb_bypass;
  assign ex_to_wb  = ex_leave && !pipe.wb_bypass;
  assign wb_done   = wb_vld_q && pipe.wb_valid;
  assign wb_to_wbd = wb_done && (wb_kind_q == trace_pkg::RK_DELAYED);
  assign wb_retire = wb_done && !wb_to_wbd;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ex_vld_q  <= 1'b0;
      ex_mis_q  <= 1'b0;
      ex_tag_q  <= '0;
      ex_kind_q <= trace_pkg::RK_NORMAL;
      wb_vld_q  <= 1'b0;
      wb_tag_q  <= '0;
      wb_kind_q <= trace_pkg::RK_NORMAL;
      wbd_vld_q <= 1'b0;
      wbd_tag_q <= '0;
      cycle_q   <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      // A dropped instruction leaves EX empty
      if (new_insn) begin
        ex_vld_q  <= !full;
        ex_mis_q  <= 1'b0;
        ex_tag_q  <= alloc_tag;
        ex_kind_q <= dec_kind;
      end else if (ex_leave) begin
        ex_vld_q <= 1'b0;
        ex_mis_q <= 1'b0;
      end else if (ex_hold) begin
        ex_mis_q <= 1'b1;
      end
      if (ex_to_wb) begin
        wb_vld_q  <= 1'b1;
        wb_tag_q  <= ex_tag_q;
        wb_kind_q <= ex_kind_q;
      end else if (wb_done) begin
        wb_vld_q <= 1'b0;
      end
      if (wb_to_wbd) begin
        wbd_vld_q <= 1'b1;
        wbd_tag_q <= wb_tag_q;
      end else begin
        wbd_vld_q <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Tagged updates
  // --------------------------------------------------
  assign mem_fire = mem.req && mem.gnt;
  // WB write while the misaligned access is still in EX
  assign wb_to_ex = !wb_vld_q && ex_vld_q && (ex_mis_q || ex_hold);

  always_comb begin
    upd_ex                = '0;
    upd_ex.tag            = ex_tag_q;
    upd_ex.set_misaligned = ex_hold;
    upd_ex.set_wb_bypass  = ex_bypass;
    upd_ex.retire         = ex_bypass;
    upd_ex.rd             = ex_wr;
    upd_ex.rd.we          = ex_wr.we && ex_vld_q;
    upd_ex.mem_set        = mem_fire && ex_vld_q;
    upd_ex.mem_we         = mem.we;
    upd_ex.mem_addr       = mem.addr;
    upd_ex.mem_wdata      = mem.we ? mem.wdata : '0;
    upd_ex.valid          = ex_hold || ex_bypass || upd_ex.rd.we || upd_ex.mem_set;

    upd_wb            = '0;
    upd_wb.tag        = wb_vld_q ? wb_tag_q : ex_tag_q;
    upd_wb.rd         = wb_wr;
    upd_wb.rd.we      = wb_wr.we && (wb_vld_q || wb_to_ex);
    upd_wb.retire     = wb_retire;
    upd_wb.retire_wbd = wbd_vld_q;
    upd_wb.wbd_tag    = wbd_tag_q;
    upd_wb.valid      = upd_wb.rd.we || wb_retire || wbd_vld_q;
  end

  // Writes and accesses that no tracked instruction owns
  assign err_ex  = ex_wr.we && !ex_vld_q;
  assign err_wb  = wb_wr.we && !wb_vld_q && !wb_to_ex;
  assign err_mem = mem_fire && !ex_vld_q;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      protocol_error <= 1'b0;
      overflow       <= 1'b0;
    end else begin
      protocol_error <= err_ex || err_wb || err_mem;
      if ((new_insn || new_ebrk) && full)
        overflow <= 1'b1;
    end
  end

endmodule

/* trace_retire_queue.sv */
// In-order retirement record store
`timescale 1ns/1ns

module trace_retire_queue (
  input  logic                          clk_i,
  input  logic                          rst_n,
  input  logic                          alloc,
  input  trace_pkg::trace_rec_t         alloc_rec,
  input  logic                          alloc_retired,
  input  trace_pkg::trace_upd_t         upd_ex,
  input  trace_pkg::trace_upd_t         upd_wb,
  input  logic                          debug_mode,
  output logic [trace_pkg::TAG_W-1:0]   alloc_tag,
  output logic                          full,
  output logic                          retire_valid,
  output trace_pkg::trace_rec_t         retire_rec
);

  trace_pkg::trace_rec_t             mem_q [trace_pkg::TRACE_DEPTH];
  logic [trace_pkg::TRACE_DEPTH-1:0] retired_q;
  logic [trace_pkg::TAG_W-1:0]       head_q, tail_q;
  logic [trace_pkg::CNT_W-1:0]       count_q;
  logic                              alloc_ok, release_head;
  // EX command applies first so a WB write to the same record wins
  trace_pkg::trace_upd_t [1:0]       upd;

  function automatic logic [trace_pkg::TAG_W-1:0] ptr_inc(
    input logic [trace_pkg::TAG_W-1:0] ptr
  );
    logic [trace_pkg::TAG_W-1:0] nxt;
    if (ptr == trace_pkg::TAG_W'(trace_pkg::TRACE_DEPTH - 1))
      nxt = '0;
    else
      nxt = ptr + 1'b1;
    return nxt;
  endfunction

  assign upd       = {upd_wb, upd_ex};
  assign alloc_tag = tail_q;
  assign full      = (count_q == trace_pkg::CNT_W'(trace_pkg::TRACE_DEPTH));
  assign alloc_ok  = alloc && !full;

  // Ebreak records wait for debug mode
  assign release_head = (count_q != '0) && retired_q[head_q] &&
                        (!mem_q[head_q].ebreak || debug_mode);

  // --------------------------------------------------
  // Record payload
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (alloc_ok)
      mem_q[tail_q] <= alloc_rec;
    for (int i = 0; i < 2; i++) begin
      if (upd[i].valid) begin
        if (upd[i].set_wb_bypass)
          mem_q[upd[i].tag].wb_bypass <= 1'b1;
        if (upd[i].set_misaligned)
          mem_q[upd[i].tag].misaligned <= 1'b1;
        if (upd[i].rd.we) begin
          mem_q[upd[i].tag].rd_written <= 1'b1;
          mem_q[upd[i].tag].rd_addr    <= upd[i].rd.addr;
          mem_q[upd[i].tag].rd_wdata   <= upd[i].rd.wdata;
        end
        // Later accesses of the same instruction are ignored
        if (upd[i].mem_set && !mem_q[upd[i].tag].mem_valid) begin
          mem_q[upd[i].tag].mem_valid <= 1'b1;
          mem_q[upd[i].tag].mem_we    <= upd[i].mem_we;
          mem_q[upd[i].tag].mem_addr  <= upd[i].mem_addr;
          mem_q[upd[i].tag].mem_wdata <= upd[i].mem_wdata;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (release_head)
      retire_rec <= mem_q[head_q];
  end

  // --------------------------------------------------
  // Pointers and retire flags
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      head_q       <= '0;
      tail_q       <= '0;
      count_q      <= '0;
      retired_q    <= '0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= release_head;
      if (release_head) begin
        retired_q[head_q] <= 1'b0;
        head_q            <= ptr_inc(head_q);
      end
      for (int i = 0; i < 2; i++) begin
        if (upd[i].valid && upd[i].retire)
          retired_q[upd[i].tag] <= 1'b1;
        if (upd[i].valid && upd[i].retire_wbd)
          retired_q[upd[i].wbd_tag] <= 1'b1;
      end
      if (alloc_ok) begin
        retired_q[tail_q] <= alloc_retired;
        tail_q            <= ptr_inc(tail_q);
      end
      case ({alloc_ok, release_head})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* trace_unit_top.sv */
// Instruction retirement tracer top
`timescale 1ns/1ns

module trace_unit_top (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  trace_pkg::dec_info_t  dec,
  input  trace_pkg::pipe_ctrl_t pipe,
  input  trace_pkg::reg_wr_t    ex_wr,
  input  trace_pkg::reg_wr_t    wb_wr,
  input  trace_pkg::mem_acc_t   mem,
  output logic                  retire_valid,
  output trace_pkg::trace_rec_t retire_rec,
  output logic                  overflow,
  output logic                  protocol_error
);

  logic                        alloc, alloc_retired, full;
  logic [trace_pkg::TAG_W-1:0] alloc_tag;
  trace_pkg::trace_rec_t       alloc_rec;
  trace_pkg::trace_upd_t       upd_ex, upd_wb;

  trace_stage_tracker u_tracker (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .dec            (dec),
    .pipe           (pipe),
    .ex_wr          (ex_wr),
    .wb_wr          (wb_wr),
    .mem            (mem),
    .alloc_tag      (alloc_tag),
    .full           (full),
    .alloc          (alloc),
    .alloc_rec      (alloc_rec),
    .alloc_retired  (alloc_retired),
    .upd_ex         (upd_ex),
    .upd_wb         (upd_wb),
    .protocol_error (protocol_error),
    .overflow       (overflow)
  );

  // Debug mode level gates release of ebreak records
  trace_retire_queue u_queue (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .alloc         (alloc),
    .alloc_rec     (alloc_rec),
    .alloc_retired (alloc_retired),
    .upd_ex        (upd_ex),
    .upd_wb        (upd_wb),
    .debug_mode    (pipe.debug_mode),
    .alloc_tag     (alloc_tag),
    .full          (full),
    .retire_valid  (retire_valid),
    .retire_rec    (retire_rec)
  );

endmodule

/* tb_trace_unit_chk.sv */
// Retirement tracer port checker
`timescale 1ns/1ns

module tb_trace_unit_chk (
  input logic                  clk_i,
  input logic                  rst_n,
  input logic                  retire_valid,
  input trace_pkg::trace_rec_t retire_rec,
  input logic                  overflow
);

  // Count of failed assertions
  int fail_cnt = 0;

  a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n)
    !$isunknown(retire_valid))
    else begin
      fail_cnt++;
      $error("retire_valid is unknown");
    end

  // Overflow is sticky until reset
  a_overflow_sticky: assert property (@(posedge clk_i) disable iff (!rst_n)
    overflow |=> overflow)
    else begin
      fail_cnt++;
      $error("overflow fell while out of reset");
    end

  a_rec_known: assert property (@(posedge clk_i) disable iff (!rst_n)
    retire_valid |-> !$isunknown(retire_rec))
    else begin
      fail_cnt++;
      $error("retire_rec has unknown bits while retire_valid is high");
    end

endmodule

bind trace_unit_top tb_trace_unit_chk i_chk (
  .clk_i        (clk_i),
  .rst_n        (rst_n),
  .retire_valid (retire_valid),
  .retire_rec   (retire_rec),
  .overflow     (overflow)
);

/* tb_trace_unit.sv */
// Retirement tracer testbench
`timescale 1ns/1ns

module tb_trace_unit;

  localparam int NUM_TESTS = 6;
  localparam int CLK_NS    = 8;

  logic                  clk_i;
  logic                  rst_n;
  trace_pkg::dec_info_t  dec;
  trace_pkg::pipe_ctrl_t pipe;
  trace_pkg::reg_wr_t    ex_wr, wb_wr;
  trace_pkg::mem_acc_t   mem;
  logic                  retire_valid, overflow, protocol_error;
  trace_pkg::trace_rec_t retire_rec;

  trace_pkg::trace_rec_t exp_q [$];
  int unsigned           lcg_state = 32'd76322;
  int                    err_cnt   = 0;
  int                    miss_cnt  = 0;
  logic [31:0]           cyc;

  trace_unit_top i_trace_unit_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  // Mirror of the free-running decode cycle counter
  always @(posedge clk_i or negedge rst_n) begin
    if (!rst_n)
      cyc <= '0;
    else
      cyc <= cyc + 1'b1;
  end

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand_pc();
    return rand32() & 32'hffff_fffc;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_rec(input trace_pkg::trace_rec_t got, input trace_pkg::trace_rec_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: record for pc %h differs", $time, exp.pc);
      $display("  got %h", got);
      $display("  exp %h", exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Records leave one per cycle, compared in program order
  always @(negedge clk_i) begin
    if (rst_n === 1'b1 && retire_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        miss_cnt++;
        $display("Unexpected record for pc %h at %0t", retire_rec.pc, $time);
      end else begin
        check_rec(retire_rec, exp_q.pop_front());
      end
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  // Strobes last one cycle, debug levels are kept
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    dec                  = '0;
    ex_wr                = '0;
    wb_wr                = '0;
    mem                  = '0;
    pipe.ex_valid        = 1'b0;
    pipe.data_misaligned = 1'b0;
    pipe.wb_bypass       = 1'b0;
    pipe.wb_valid        = 1'b0;
  endtask

  task automatic decode_insn(input logic [31:0] pc, input logic [31:0] instr,
                             output trace_pkg::trace_rec_t rec);
    dec.pc          = pc;
    dec.instr       = instr;
    dec.id_valid    = 1'b1;
    dec.is_decoding = 1'b1;
    rec             = '0;
    rec.pc          = pc;
    rec.instr       = instr;
    rec.cycle       = cyc;
  endtask

  task automatic decode_ebreak(input logic [31:0] pc, output trace_pkg::trace_rec_t rec);
    dec.pc          = pc;
    dec.instr       = trace_pkg::INSN_EBREAK;
    dec.is_decoding = 1'b1;
    dec.ebrk_insn   = 1'b1;
    rec             = '0;
    rec.pc          = pc;
    rec.instr       = trace_pkg::INSN_EBREAK;
    rec.ebreak      = 1'b1;
    rec.cycle       = cyc;
  endtask

  task automatic wait_drain(input string name);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 30) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      miss_cnt += exp_q.size();
      $display("Test %s: %0d expected records never retired", name, exp_q.size());
      exp_q.delete();
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_normal();
    trace_pkg::trace_rec_t rec;
    logic [31:0]           r;
    r = rand32();
    next_cycle();
    decode_insn(rand_pc(), rand32() | 32'h3, rec);
    rec.rd_written = 1'b1;
    rec.rd_addr    = {1'b0, r[4:0]};
    rec.rd_wdata   = rand32();
    exp_q.push_back(rec);
    next_cycle();
    pipe.ex_valid = 1'b1;
    ex_wr         = '{we: 1'b1, addr: rec.rd_addr, wdata: rec.rd_wdata};
    next_cycle();
    pipe.wb_valid = 1'b1;
    next_cycle();
    wait_drain("normal");
  endtask

  task automatic test_misaligned();
    trace_pkg::trace_rec_t rec;
    logic [31:0]           r, maddr;
    r     = rand32();
    maddr = rand32() | 32'h1;
    next_cycle();
    decode_insn(rand_pc(), rand32() | 32'h3, rec);
    rec.misaligned = 1'b1;
    rec.mem_valid  = 1'b1;
    rec.mem_addr   = maddr;
    rec.rd_written = 1'b1;
    rec.rd_addr    = {1'b0, r[4:0]};
    rec.rd_wdata   = rand32();
    exp_q.push_back(rec);
    next_cycle();
    pipe.ex_valid        = 1'b1;
    pipe.data_misaligned = 1'b1;
    mem                  = '{req: 1'b1, gnt: 1'b1, we: 1'b0, addr: maddr, wdata: '0};
    // Second half of the access must not replace the first
    next_cycle();
    pipe.ex_valid        = 1'b1;
    pipe.data_misaligned = 1'b1;
    mem                  = '{req: 1'b1, gnt: 1'b1, we: 1'b0, addr: maddr + 32'd4, wdata: '0};
    wb_wr                = '{we: 1'b1, addr: rec.rd_addr, wdata: rec.rd_wdata};
    next_cycle();
    pipe.ex_valid = 1'b1;
    next_cycle();
    pipe.wb_valid = 1'b1;
    next_cycle();
    wait_drain("misaligned");
  endtask

  task automatic test_bypass_order();
    trace_pkg::trace_rec_t rec_a, rec_b;
    logic [31:0]           r;
    r = rand32();
    next_cycle();
    decode_insn(rand_pc(), rand32() | 32'h3, rec_a);
    rec_a.wb_bypass  = 1'b1;
    rec_a.rd_written = 1'b1;
    rec_a.rd_addr    = {1'b0, r[4:0]};
    rec_a.rd_wdata   = rand32();
    exp_q.push_back(rec_a);
    next_cycle();
    decode_insn(rand_pc(), rand32() | 32'h3, rec_b);
    exp_q.push_back(rec_b);
    pipe.ex_valid  = 1'b1;
    pipe.wb_bypass = 1'b1;
    ex_wr          = '{we: 1'b1, addr: rec_a.rd_addr, wdata: rec_a.rd_wdata};
    next_cycle();
    pipe.ex_valid = 1'b1;
    next_cycle();
    pipe.wb_valid = 1'b1;
    next_cycle();
    wait_drain("bypass");
  endtask

  task automatic test_delayed();
    trace_pkg::trace_rec_t rec_m, rec_n;
    next_cycle();
    decode_insn(rand_pc(), trace_pkg::INSN_MRET, rec_m);
    exp_q.push_back(rec_m);
    next_cycle();
    decode_insn(rand_pc(), rand32() | 32'h3, rec_n);
    exp_q.push_back(rec_n);
    pipe.ex_valid = 1'b1;
    next_cycle();
    pipe.ex_valid = 1'b1;
    pipe.wb_valid = 1'b1;
    next_cycle();
    pipe.wb_valid = 1'b1;
    next_cycle();
    // Mret spends this cycle in WB-delay, so nothing is out yet
    check_flag(retire_valid, 1'b0, "retire_valid while mret is in WB-delay");
    wait_drain("delayed");
  endtask

  task automatic test_debug_ebreak();
    trace_pkg::trace_rec_t rec;
    next_cycle();
    pipe.ebrk_force_debug_mode = 1'b1;
    decode_ebreak(rand_pc(), rec);
    // Any record in this window is flagged by the monitor
    repeat (6) next_cycle();
    pipe.ebrk_force_debug_mode = 1'b0;
    exp_q.push_back(rec);
    pipe.debug_mode = 1'b1;
    wait_drain("debug ebreak");
    next_cycle();
    pipe.debug_mode = 1'b0;
  endtask

  task automatic test_errors();
    trace_pkg::trace_rec_t rec;
    next_cycle();
    wb_wr = '{we: 1'b1, addr: 6'd5, wdata: rand32()};
    next_cycle();
    check_flag(protocol_error, 1'b1, "protocol_error on orphan WB write");
    next_cycle();
    check_flag(protocol_error, 1'b0, "protocol_error after one cycle");
    check_flag(overflow, 1'b0, "overflow before fill");
    pipe.ebrk_force_debug_mode = 1'b1;
    for (int i = 0; i <= trace_pkg::TRACE_DEPTH; i++) begin
      decode_ebreak(rand_pc(), rec);
      if (i < trace_pkg::TRACE_DEPTH)
        exp_q.push_back(rec);
      next_cycle();
    end
    pipe.ebrk_force_debug_mode = 1'b0;
    check_flag(overflow, 1'b1, "overflow after fifth decode");
    pipe.debug_mode = 1'b1;
    wait_drain("overflow");
    repeat (3) next_cycle();
    check_flag(overflow, 1'b1, "overflow after drain");
    pipe.debug_mode = 1'b0;
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial begin
    rst_n = 1'b0;
    dec   = '0;
    pipe  = '0;
    ex_wr = '0;
    wb_wr = '0;
    mem   = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n = 1'b1;
    check_flag(retire_valid, 1'b0, "retire_valid after reset");
    check_flag(overflow, 1'b0, "overflow after reset");
    check_flag(protocol_error, 1'b0, "protocol_error after reset");
    test_normal();
    test_misaligned();
    test_bypass_order();
    test_delayed();
    test_debug_ebreak();
    test_errors();
    repeat (4) next_cycle();
    $display("Summary: %0d check errors, %0d missing or unexpected records, %0d assertion failures",
             err_cnt, miss_cnt, i_trace_unit_top.i_chk.fail_cnt);
    if (err_cnt == 0 && miss_cnt == 0 && i_trace_unit_top.i_chk.fail_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  initial begin
    #(60 * NUM_TESTS * CLK_NS);
    $display("Watchdog timeout: tests did not finish within %0d cycles", 60 * NUM_TESTS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* verilog.f */
trace_pkg.sv
trace_stage_tracker.sv
trace_retire_queue.sv
trace_unit_top.sv
tb_trace_unit_chk.sv
tb_trace_unit.sv

/* Bender.yml */
package:
  name: trace_unit

sources:
  - trace_pkg.sv
  - trace_stage_tracker.sv
  - trace_retire_queue.sv
  - trace_unit_top.sv
  - target: simulation
    files:
      - tb_trace_unit_chk.sv
      - tb_trace_unit.sv
